/* exec_stage.f */
+incdir+testbench
rtl/riscv_pkg.sv
rtl/instr_decoder.sv
rtl/controller.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/exec_stage.sv
testbench/exec_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_stage_tb \
	-f exec_stage.f -o exec_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/exec_stage_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* testbench/exec_ref.svh */
// Execute stage reference model
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

typedef struct packed {
	logic        rd_we;
	logic        chk_rd;
	logic [4:0]  rd_addr;
	logic [31:0] rd_data;
	logic        load;
	logic        store;
	logic        chk_mem;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [2:0]  funct3;
	logic        taken;
	logic        chk_target;
	logic [31:0] target;
	logic        illegal;
} expect_t;

function automatic logic [31:0] r_type(input logic [31:0] f7, rs2, rs1, f3, rd);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
endfunction

function automatic logic [31:0] i_type(input logic [31:0] imm, rs1, f3, rd,
		input logic [6:0] opc);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] s_type(input logic [31:0] imm, rs2, rs1, f3);
	return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
endfunction

function automatic logic [31:0] b_type(input logic [31:0] imm, rs2, rs1, f3);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], BRANCH};
endfunction

// Upper 20 bits of imm become the U immediate
function automatic logic [31:0] u_type(input logic [31:0] imm, rd, input logic [6:0] opc);
	return {imm[31:12], rd[4:0], opc};
endfunction

function automatic logic [31:0] j_type(input logic [31:0] imm, rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], JAL};
endfunction

// RV32I integer semantics by funct3
function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, b);
	case (f3)
		3'd0:    return alt ? a - b : a + b;
		3'd1:    return a << b[4:0];
		3'd2:    return {31'b0, $signed(a) < $signed(b)};
		3'd3:    return {31'b0, a < b};
		3'd4:    return a ^ b;
		3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6:    return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_holds(input logic [2:0] f3, input logic [31:0] a, b);
	case (f3)
		3'd0:    return a == b;
		3'd1:    return a != b;
		3'd4:    return $signed(a) < $signed(b);
		3'd5:    return $signed(a) >= $signed(b);
		3'd6:    return a < b;
		default: return a >= b;
	endcase
endfunction

function automatic expect_t exec_model(input logic [31:0] instr, pc, rs1, rs2);
	expect_t     e;
	logic [6:0]  opc;
	logic [6:0]  f7;
	logic [2:0]  f3;
	logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm, res;
	logic        wr, bad;
	e     = '0;
	opc   = instr[6:0];
	f7    = instr[31:25];
	f3    = instr[14:12];
	i_imm = {{20{instr[31]}}, instr[31:20]};
	s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	u_imm = {instr[31:12], 12'b0};
	j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	wr    = 1'b0;
	bad   = 1'b0;
	res   = 32'd0;
	case (opc)
		OP: begin
			if ((f7 & 7'b1011111) != 7'd0 || (f7[5] && f3 != 3'd0 && f3 != 3'd5))
				bad = 1'b1;
			else begin
				wr  = 1'b1;
				res = compute_alu(f3, f7[5], rs1, rs2);
			end
		end
		OP_IMM: begin
			if ((f3 == 3'd1 && f7 != 7'd0) ||
					(f3 == 3'd5 && (f7 & 7'b1011111) != 7'd0))
				bad = 1'b1;
			else begin
				wr  = 1'b1;
				res = compute_alu(f3, f3 == 3'd5 && f7[5], rs1, i_imm);
			end
		end
		LUI: begin
			wr  = 1'b1;
			res = u_imm;
		end
		AUIPC: begin
			wr  = 1'b1;
			res = pc + u_imm;
		end
		LOAD: begin
			if (f3 == 3'd3 || f3 > 3'd5)
				bad = 1'b1;
			else begin
				wr        = 1'b1;
				e.load    = 1'b1;
				e.chk_mem = 1'b1;
				res       = rs1 + i_imm;
			end
		end
		STORE: begin
			if (f3 > 3'd2)
				bad = 1'b1;
			else begin
				e.store   = 1'b1;
				e.chk_mem = 1'b1;
				res       = rs1 + s_imm;
			end
		end
		BRANCH: begin
			if (f3 == 3'd2 || f3 == 3'd3)
				bad = 1'b1;
			else begin
				e.chk_target = 1'b1;
				e.target     = pc + b_imm;
				e.taken      = branch_holds(f3, rs1, rs2);
			end
		end
		JAL: begin
			wr           = 1'b1;
			res          = pc + 32'd4;
			e.taken      = 1'b1;
			e.chk_target = 1'b1;
			e.target     = pc + j_imm;
		end
		JALR: begin
			if (f3 != 3'd0)
				bad = 1'b1;
			else begin
				wr           = 1'b1;
				res          = pc + 32'd4;
				e.taken      = 1'b1;
				e.chk_target = 1'b1;
				e.target     = (rs1 + i_imm) & 32'hffff_fffe;
			end
		end
		default: bad = 1'b1;
	endcase
	e.illegal = bad;
	e.chk_rd  = wr;
	e.rd_we   = wr && (instr[11:7] != 5'd0);
	e.rd_addr = instr[11:7];
	e.rd_data = res;
	e.addr    = res;
	e.wdata   = rs2;
	e.funct3  = f3;
	return e;
endfunction

`endif

/* testbench/exec_stage_tb.sv */
// Execute stage testbench
module exec_stage_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import riscv_pkg::*;
	`include "exec_ref.svh"

	localparam int RESET_CYCLES   = 2;
	localparam int IDLE_CYCLES    = 4;
	localparam int RAND_OPS       = 200;
	localparam int MEM_TESTS      = 10;
	localparam int BRANCH_TESTS   = 30;
	localparam int JUMP_TESTS     = 3;
	localparam int ILLEGAL_TESTS  = 11;
	localparam int DRAIN_CYCLES   = 4;
	localparam int CYCLE_LIMIT    = RESET_CYCLES + IDLE_CYCLES + RAND_OPS + MEM_TESTS +
		BRANCH_TESTS + JUMP_TESTS + ILLEGAL_TESTS + DRAIN_CYCLES + 20;

	logic        clk_i = 1'b0;
	logic        arst_n_i;
	logic        valid_i;
	logic [31:0] instr_i, pc_i, rs1_data_i, rs2_data_i;
	logic        valid_o, rd_we_o, mem_load_o, mem_store_o, branch_taken_o, illegal_o;
	logic [4:0]  rd_addr_o;
	logic [31:0] rd_data_o, mem_addr_o, mem_wdata_o, branch_target_o;
	logic [2:0]  mem_funct3_o;

	logic [31:0] lfsr = 32'h0bec_dd46;
	expect_t     exp_q[$];
	string       name_q[$];
	int          cycle_count = 0;

	// Equal, signed less, signed greater, unsigned less, unsigned greater
	logic [31:0] pair_a [0:4] = '{32'h1234_5678, 32'hffff_fffb, 32'd3, 32'd2, 32'd7};
	logic [31:0] pair_b [0:4] = '{32'h1234_5678, 32'd3, 32'hffff_fffb, 32'd7, 32'd2};

	exec_stage exec_stage_inst (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.valid_i         (valid_i),
		.instr_i         (instr_i),
		.pc_i            (pc_i),
		.rs1_data_i      (rs1_data_i),
		.rs2_data_i      (rs2_data_i),
		.valid_o         (valid_o),
		.rd_we_o         (rd_we_o),
		.rd_addr_o       (rd_addr_o),
		.rd_data_o       (rd_data_o),
		.mem_load_o      (mem_load_o),
		.mem_store_o     (mem_store_o),
		.mem_addr_o      (mem_addr_o),
		.mem_wdata_o     (mem_wdata_o),
		.mem_funct3_o    (mem_funct3_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.illegal_o       (illegal_o)
	);

	always #50 clk_i = ~clk_i;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
				test, field, expected, actual));
	endtask

	task automatic drive_instr(input string name, input logic [31:0] instr, pc, rs1, rs2);
		@(negedge clk_i);
		valid_i    = 1'b1;
		instr_i    = instr;
		pc_i       = pc;
		rs1_data_i = rs1;
		rs2_data_i = rs2;
		exp_q.push_back(exec_model(instr, pc, rs1, rs2));
		name_q.push_back(name);
	endtask

	task automatic idle_cycle();
		@(negedge clk_i);
		valid_i = 1'b0;
	endtask

	initial begin : compare_proc
		expect_t e;
		string   nm;
		logic    strobed;
		forever begin
			@(posedge clk_i);
			strobed = valid_i && arst_n_i;
			// Registered outputs are settled by the falling edge
			@(negedge clk_i);
			if (strobed) begin
				e  = exp_q.pop_front();
				nm = name_q.pop_front();
				check_value(nm, "valid_o", 32'd1, 32'(valid_o));
				check_value(nm, "rd_we_o", 32'(e.rd_we), 32'(rd_we_o));
				check_value(nm, "mem_load_o", 32'(e.load), 32'(mem_load_o));
				check_value(nm, "mem_store_o", 32'(e.store), 32'(mem_store_o));
				check_value(nm, "branch_taken_o", 32'(e.taken), 32'(branch_taken_o));
				check_value(nm, "illegal_o", 32'(e.illegal), 32'(illegal_o));
				if (e.chk_rd) begin
					check_value(nm, "rd_addr_o", 32'(e.rd_addr), 32'(rd_addr_o));
					check_value(nm, "rd_data_o", e.rd_data, rd_data_o);
				end
				if (e.chk_mem) begin
					check_value(nm, "mem_addr_o", e.addr, mem_addr_o);
					check_value(nm, "mem_wdata_o", e.wdata, mem_wdata_o);
					check_value(nm, "mem_funct3_o", 32'(e.funct3), 32'(mem_funct3_o));
				end
				if (e.chk_target)
					check_value(nm, "branch_target_o", e.target, branch_target_o);
			end else begin
				check_value("idle", "valid_o", 32'd0, 32'(valid_o));
				check_value("idle", "rd_we_o", 32'd0, 32'(rd_we_o));
				check_value("idle", "mem_load_o", 32'd0, 32'(mem_load_o));
				check_value("idle", "mem_store_o", 32'd0, 32'(mem_store_o));
				check_value("idle", "branch_taken_o", 32'd0, 32'(branch_taken_o));
				check_value("idle", "illegal_o", 32'd0, 32'(illegal_o));
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycle_count++;
		end
		abort_run($sformatf("Timeout after %0d cycles", cycle_count));
	end

	initial begin : stimulus
		logic [31:0] f3, rd, imm, pc;
		arst_n_i   = 1'b0;
		valid_i    = 1'b0;
		instr_i    = 32'd0;
		pc_i       = 32'd0;
		rs1_data_i = 32'd0;
		rs2_data_i = 32'd0;
		repeat (RESET_CYCLES) @(negedge clk_i);
		arst_n_i = 1'b1;
		repeat (IDLE_CYCLES) idle_cycle();

		for (int i = 0; i < RAND_OPS; i++) begin
			f3 = rand_bits(3);
			rd = rand_bits(5);
			pc = rand_bits(30) << 2;
			if (rand_bits(1) == 32'd1) begin
				imm = ((f3 == 32'd0) || (f3 == 32'd5)) ? (rand_bits(1) << 5) : 32'd0;
				drive_instr("rand_r", r_type(imm, rand_bits(5), rand_bits(5), f3, rd),
					pc, rand_bits(32), rand_bits(32));
			end else begin
				if (f3 == 32'd1)
					imm = rand_bits(5);
				else if (f3 == 32'd5)
					imm = rand_bits(5) | (rand_bits(1) << 10);
				else
					imm = rand_bits(12);
				drive_instr("rand_i", i_type(imm, rand_bits(5), f3, rd, OP_IMM),
					pc, rand_bits(32), rand_bits(32));
			end
		end

		drive_instr("lui", u_type(rand_bits(32), 7, LUI), rand_bits(30) << 2,
			rand_bits(32), rand_bits(32));
		drive_instr("auipc", u_type(rand_bits(32), 9, AUIPC), rand_bits(30) << 2,
			rand_bits(32), rand_bits(32));
		for (int k = 0; k < 6; k++) begin
			if (k != 3)
				drive_instr("load", i_type(rand_bits(12), 2, k, 4, LOAD),
					rand_bits(30) << 2, rand_bits(32), rand_bits(32));
		end
		for (int k = 0; k < 3; k++)
			drive_instr("store", s_type(rand_bits(12), 3, 2, k),
				rand_bits(30) << 2, rand_bits(32), rand_bits(32));

		for (int k = 0; k < 8; k++) begin
			if (k != 2 && k != 3) begin
				for (int j = 0; j < 5; j++)
					drive_instr("branch", b_type(rand_bits(12) << 1, 2, 1, k),
						rand_bits(30) << 2, pair_a[j], pair_b[j]);
			end
		end

		drive_instr("jal", j_type(rand_bits(20) << 1, 1), rand_bits(30) << 2,
			rand_bits(32), rand_bits(32));
		// Odd rs1 with even offset exercises the cleared target bit
		drive_instr("jalr", i_type(rand_bits(11) << 1, 5, 0, 1, JALR),
			rand_bits(30) << 2, rand_bits(32) | 32'd1, rand_bits(32));
		drive_instr("jalr_x0", i_type(rand_bits(12), 5, 0, 0, JALR),
			rand_bits(30) << 2, rand_bits(32), rand_bits(32));

		drive_instr("bad_opcode", i_type(0, 1, 0, 5, 7'h0b), 32'h100, 32'd1, 32'd2);
		drive_instr("all_ones", 32'hffff_ffff, 32'h104, 32'd1, 32'd2);
		drive_instr("all_zeros", 32'h0000_0000, 32'h108, 32'd1, 32'd2);
		drive_instr("mul_funct7", r_type(32'h01, 2, 1, 0, 5), 32'h10c, 32'd1, 32'd2);
		drive_instr("sll_alt", r_type(32'h20, 2, 1, 1, 5), 32'h110, 32'd1, 32'd2);
		drive_instr("slli_alt", i_type(32'h400, 1, 1, 5, OP_IMM), 32'h114, 32'd1, 32'd2);
		drive_instr("srli_funct7", i_type(32'h020, 1, 5, 5, OP_IMM), 32'h118, 32'd1, 32'd2);
		drive_instr("load_funct3", i_type(0, 1, 3, 5, LOAD), 32'h11c, 32'd1, 32'd2);
		drive_instr("store_funct3", s_type(0, 2, 1, 4), 32'h120, 32'd1, 32'd2);
		drive_instr("branch_funct3", b_type(8, 2, 1, 2), 32'h124, 32'd1, 32'd1);
		drive_instr("jalr_funct3", i_type(0, 1, 1, 5, JALR), 32'h128, 32'd1, 32'd2);

		repeat (DRAIN_CYCLES) idle_cycle();
		$display("All tests passed");
		$finish;
	end

endmodule

/* rtl/exec_stage.sv */
// Decode and execute stage
module exec_stage (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        valid_i,
	input  logic [31:0] instr_i,
	input  logic [31:0] pc_i,
	input  logic [31:0] rs1_data_i,
	input  logic [31:0] rs2_data_i,
	output logic        valid_o,
	output logic        rd_we_o,
	output logic [4:0]  rd_addr_o,
	output logic [31:0] rd_data_o,
	output logic        mem_load_o,
	output logic        mem_store_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [2:0]  mem_funct3_o,
	output logic        branch_taken_o,
	output logic [31:0] branch_target_o,
	output logic        illegal_o
);

	import riscv_pkg::*;

	dcode_e      decoded_op;
	alu_op_e     alu_op;
	logic        write_en, imm_sel, stype, upper, pc_alu;
	logic        load, store, branch, brn_inv, jal, jalr;
	logic        cmp_less, brn_sense;
	logic [31:0] imm, op_a, op_b, alu_result, target, link;
	logic        taken, legal, go;

	instr_decoder instr_decoder_inst (
		.instr_i      (instr_i),
		.decoded_op_o (decoded_op)
	);

	controller controller_inst (
		.decoded_op_i    (decoded_op),
		.alu_op_ctrl_o   (alu_op),
		.write_en_ctrl_o (write_en),
		.imm_ctrl_o      (imm_sel),
		.stype_ctrl_o    (stype),
		.upper_ctrl_o    (upper),
		.pc_alu_ctrl_o   (pc_alu),
		.load_ctrl_o     (load),
		.store_ctrl_o    (store),
		.branch_ctrl_o   (branch),
		.brn_inv_ctrl_o  (brn_inv),
		.jal_ctrl_o      (jal),
		.jalr_ctrl_o     (jalr)
	);

	imm_gen imm_gen_inst (
		.instr_i (instr_i),
		.stype_i (stype),
		.imm_o   (imm)
	);

	// LUI takes zero, AUIPC and JAL take the PC
	assign op_a = pc_alu ? pc_i : (upper ? 32'd0 : rs1_data_i);
	assign op_b = (imm_sel || upper) ? imm : rs2_data_i;

	alu alu_inst (
		.alu_op_i (alu_op),
		.a_i      (op_a),
		.b_i      (op_b),
		.result_o (alu_result)
	);

	// Less-than compares take the branch on a nonzero result
	assign cmp_less  = (alu_op == ALU_SLT) || (alu_op == ALU_SLTU);
	assign brn_sense = brn_inv ^ cmp_less;

	branch_unit branch_unit_inst (
		.pc_i         (pc_i),
		.rs1_i        (rs1_data_i),
		.imm_i        (imm),
		.alu_result_i (alu_result),
		.branch_i     (branch),
		.brn_inv_i    (brn_sense),
		.jal_i        (jal),
		.jalr_i       (jalr),
		.taken_o      (taken),
		.target_o     (target)
	);

	assign link  = pc_i + 32'd4;
	assign legal = (decoded_op != DCODED_ILLEGAL);
	assign go    = valid_i && legal;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o        <= 1'b0;
			rd_we_o        <= 1'b0;
			mem_load_o     <= 1'b0;
			mem_store_o    <= 1'b0;
			branch_taken_o <= 1'b0;
			illegal_o      <= 1'b0;
		end else begin
			valid_o        <= valid_i;
			rd_we_o        <= go && write_en && (instr_i[11:7] != 5'd0);
			mem_load_o     <= go && load;
			mem_store_o    <= go && store;
			branch_taken_o <= go && taken;
			illegal_o      <= valid_i && !legal;
		end
	end

	// Payload holds between strobes
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			rd_addr_o       <= instr_i[11:7];
			rd_data_o       <= (jal || jalr) ? link : alu_result;
			mem_addr_o      <= alu_result;
			mem_wdata_o     <= rs2_data_i;
			mem_funct3_o    <= instr_i[14:12];
			branch_target_o <= target;
		end
	end

	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		1'b1 |=> (valid_o == $past(valid_i)))
		else $error("valid_o does not follow valid_i");

	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		illegal_o |-> !(rd_we_o || mem_load_o || mem_store_o || branch_taken_o))
		else $error("illegal instruction produced a request");

endmodule

/* rtl/branch_unit.sv */
// Branch and jump resolution
module branch_unit (
	input  logic [31:0] pc_i,
	input  logic [31:0] rs1_i,
	input  logic [31:0] imm_i,
	input  logic [31:0] alu_result_i,
	input  logic        branch_i,
	input  logic        brn_inv_i,
	input  logic        jal_i,
	input  logic        jalr_i,
	output logic        taken_o,
	output logic [31:0] target_o
);

	logic        is_zero;
	logic        cond;
	logic [31:0] jalr_sum;

	// Zero result is equal for SUB and not-less for SLT/SLTU
	assign is_zero = (alu_result_i == 32'd0);
	assign cond    = is_zero ^ brn_inv_i;

	assign jalr_sum = rs1_i + imm_i;
	assign target_o = jalr_i ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;

	assign taken_o = jal_i | jalr_i | (branch_i & cond);

endmodule

/* rtl/alu.sv */
// 32-bit ALU
module alu (
	input  riscv_pkg::alu_op_e alu_op_i,
	input  logic [31:0]        a_i,
	input  logic [31:0]        b_i,
	output logic [31:0]        result_o
);

	import riscv_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = b_i[4:0];
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:  result_o = a_i + b_i;
			ALU_SUB:  result_o = a_i - b_i;
			ALU_SLL:  result_o = a_i << shamt;
			ALU_SRL:  result_o = a_i >> shamt;
			ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
			ALU_AND:  result_o = a_i & b_i;
			ALU_OR:   result_o = a_i | b_i;
			ALU_XOR:  result_o = a_i ^ b_i;
			ALU_SLT:  result_o = {31'b0, lt_signed};
			ALU_SLTU: result_o = {31'b0, lt_unsigned};
			default:  result_o = a_i + b_i;
		endcase
	end

endmodule

/* rtl/imm_gen.sv */
// Immediate generator
module imm_gen (
	input  logic [31:0] instr_i,
	input  logic        stype_i,
	output logic [31:0] imm_o
);

	import riscv_pkg::*;

	opcode_e opcode;

	assign opcode = opcode_e'(instr_i[6:0]);

	always_comb begin
		case (opcode)
			LUI, AUIPC:
				imm_o = {instr_i[31:12], 12'b0};
			JAL:
				imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
					instr_i[30:21], 1'b0};
			BRANCH:
				imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
					instr_i[11:8], 1'b0};
			default: begin
				// Store offset is split around rd
				if (stype_i)
					imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
				else
					imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
			end
		endcase
	end

endmodule

/* rtl/controller.sv */
// Datapath controller
module controller (
	input  riscv_pkg::dcode_e   decoded_op_i,
	output riscv_pkg::alu_op_e  alu_op_ctrl_o,
	output logic                write_en_ctrl_o,
	output logic                imm_ctrl_o,
	output logic                stype_ctrl_o,
	output logic                upper_ctrl_o,
	output logic                pc_alu_ctrl_o,
	output logic                load_ctrl_o,
	output logic                store_ctrl_o,
	output logic                branch_ctrl_o,
	output logic                brn_inv_ctrl_o,
	output logic                jal_ctrl_o,
	output logic                jalr_ctrl_o
);

	import riscv_pkg::*;

	always_comb begin
		case (decoded_op_i)
			DCODED_ADD, DCODED_ADDI, DCODED_AUIPC, DCODED_LUI,
			DCODED_LB, DCODED_LBU, DCODED_LH, DCODED_LHU, DCODED_LW,
			DCODED_SB, DCODED_SH, DCODED_SW, DCODED_JAL, DCODED_JALR:
				alu_op_ctrl_o = ALU_ADD;
			DCODED_SUB, DCODED_BEQ, DCODED_BNE:
				alu_op_ctrl_o = ALU_SUB;
			DCODED_SLT, DCODED_SLTI, DCODED_BLT, DCODED_BGE:
				alu_op_ctrl_o = ALU_SLT;
			DCODED_SLTU, DCODED_SLTIU, DCODED_BLTU, DCODED_BGEU:
				alu_op_ctrl_o = ALU_SLTU;
			DCODED_OR, DCODED_ORI:   alu_op_ctrl_o = ALU_OR;
			DCODED_AND, DCODED_ANDI: alu_op_ctrl_o = ALU_AND;
			DCODED_XOR, DCODED_XORI: alu_op_ctrl_o = ALU_XOR;
			DCODED_SLL, DCODED_SLLI: alu_op_ctrl_o = ALU_SLL;
			DCODED_SRL, DCODED_SRLI: alu_op_ctrl_o = ALU_SRL;
			DCODED_SRA, DCODED_SRAI: alu_op_ctrl_o = ALU_SRA;
			default:                 alu_op_ctrl_o = ALU_ADD;
		endcase
	end

	always_comb begin
		write_en_ctrl_o = 1'b0;
		imm_ctrl_o      = 1'b0;
		stype_ctrl_o    = 1'b0;
		upper_ctrl_o    = 1'b0;
		pc_alu_ctrl_o   = 1'b0;
		load_ctrl_o     = 1'b0;
		store_ctrl_o    = 1'b0;
		branch_ctrl_o   = 1'b0;
		brn_inv_ctrl_o  = 1'b0;
		jal_ctrl_o      = 1'b0;
		jalr_ctrl_o     = 1'b0;
		case (decoded_op_i)
			DCODED_ADD, DCODED_SUB, DCODED_SLL, DCODED_SRL, DCODED_SRA,
			DCODED_AND, DCODED_OR, DCODED_XOR, DCODED_SLT, DCODED_SLTU: begin
				write_en_ctrl_o = 1'b1;
			end
			DCODED_ADDI, DCODED_SLLI, DCODED_SRLI, DCODED_SRAI, DCODED_ANDI,
			DCODED_ORI, DCODED_XORI, DCODED_SLTI, DCODED_SLTIU: begin
				write_en_ctrl_o = 1'b1;
				imm_ctrl_o      = 1'b1;
			end
			// Zero plus U immediate
			DCODED_LUI: begin
				write_en_ctrl_o = 1'b1;
				upper_ctrl_o    = 1'b1;
			end
			DCODED_AUIPC: begin
				write_en_ctrl_o = 1'b1;
				imm_ctrl_o      = 1'b1;
				upper_ctrl_o    = 1'b1;
				pc_alu_ctrl_o   = 1'b1;
			end
			DCODED_LB, DCODED_LBU, DCODED_LH, DCODED_LHU, DCODED_LW: begin
				write_en_ctrl_o = 1'b1;
				imm_ctrl_o      = 1'b1;
				load_ctrl_o     = 1'b1;
			end
			DCODED_SB, DCODED_SH, DCODED_SW: begin
				imm_ctrl_o      = 1'b1;
				stype_ctrl_o    = 1'b1;
				store_ctrl_o    = 1'b1;
			end
			DCODED_BEQ, DCODED_BLT, DCODED_BLTU: begin
				branch_ctrl_o   = 1'b1;
			end
			DCODED_BNE, DCODED_BGE, DCODED_BGEU: begin
				branch_ctrl_o   = 1'b1;
				brn_inv_ctrl_o  = 1'b1;
			end
			DCODED_JAL: begin
				write_en_ctrl_o = 1'b1;
				imm_ctrl_o      = 1'b1;
				pc_alu_ctrl_o   = 1'b1;
				jal_ctrl_o      = 1'b1;
			end
			DCODED_JALR: begin
				write_en_ctrl_o = 1'b1;
				imm_ctrl_o      = 1'b1;
				jalr_ctrl_o     = 1'b1;
			end
			default: begin
				write_en_ctrl_o = 1'b0;
			end
		endcase
	end

	assert property (@(decoded_op_i) !(load_ctrl_o && store_ctrl_o))
		else $error("load and store requested together");

endmodule

/* rtl/instr_decoder.sv */
// Instruction decoder
module instr_decoder (
	input  logic [31:0]        instr_i,
	output riscv_pkg::dcode_e  decoded_op_o
);

	import riscv_pkg::*;

	opcode_e     opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic        funct7_ok;
	logic        alt;

	assign opcode = opcode_e'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// Only bit 5 of funct7 may be set
	assign funct7_ok = (funct7 & 7'b1011111) == 7'b0000000;
	assign alt       = funct7[5];

	always_comb begin
		decoded_op_o = DCODED_ILLEGAL;
		case (opcode)
			OP: begin
				if (funct7_ok) begin
					case (funct3)
						3'b000:  decoded_op_o = alt ? DCODED_SUB : DCODED_ADD;
						3'b101:  decoded_op_o = alt ? DCODED_SRA : DCODED_SRL;
						3'b001:  decoded_op_o = alt ? DCODED_ILLEGAL : DCODED_SLL;
						3'b010:  decoded_op_o = alt ? DCODED_ILLEGAL : DCODED_SLT;
						3'b011:  decoded_op_o = alt ? DCODED_ILLEGAL : DCODED_SLTU;
						3'b100:  decoded_op_o = alt ? DCODED_ILLEGAL : DCODED_XOR;
						3'b110:  decoded_op_o = alt ? DCODED_ILLEGAL : DCODED_OR;
						default: decoded_op_o = alt ? DCODED_ILLEGAL : DCODED_AND;
					endcase
				end
			end
			OP_IMM: begin
				case (funct3)
					3'b000:  decoded_op_o = DCODED_ADDI;
					3'b010:  decoded_op_o = DCODED_SLTI;
					3'b011:  decoded_op_o = DCODED_SLTIU;
					3'b100:  decoded_op_o = DCODED_XORI;
					3'b110:  decoded_op_o = DCODED_ORI;
					3'b111:  decoded_op_o = DCODED_ANDI;
					3'b001:  decoded_op_o = (funct7 == 7'b0) ? DCODED_SLLI : DCODED_ILLEGAL;
					default: begin
						if (funct7_ok)
							decoded_op_o = alt ? DCODED_SRAI : DCODED_SRLI;
					end
				endcase
			end
			LUI:   decoded_op_o = DCODED_LUI;
			AUIPC: decoded_op_o = DCODED_AUIPC;
			LOAD: begin
				case (funct3)
					3'b000:  decoded_op_o = DCODED_LB;
					3'b001:  decoded_op_o = DCODED_LH;
					3'b010:  decoded_op_o = DCODED_LW;
					3'b100:  decoded_op_o = DCODED_LBU;
					3'b101:  decoded_op_o = DCODED_LHU;
					default: decoded_op_o = DCODED_ILLEGAL;
				endcase
			end
			STORE: begin
				case (funct3)
					3'b000:  decoded_op_o = DCODED_SB;
					3'b001:  decoded_op_o = DCODED_SH;
					3'b010:  decoded_op_o = DCODED_SW;
					default: decoded_op_o = DCODED_ILLEGAL;
				endcase
			end
			BRANCH: begin
				case (funct3)
					3'b000:  decoded_op_o = DCODED_BEQ;
					3'b001:  decoded_op_o = DCODED_BNE;
					3'b100:  decoded_op_o = DCODED_BLT;
					3'b101:  decoded_op_o = DCODED_BGE;
					3'b110:  decoded_op_o = DCODED_BLTU;
					3'b111:  decoded_op_o = DCODED_BGEU;
					default: decoded_op_o = DCODED_ILLEGAL;
				endcase
			end
			JAL:  decoded_op_o = DCODED_JAL;
			JALR: decoded_op_o = (funct3 == 3'b000) ? DCODED_JALR : DCODED_ILLEGAL;
			default: decoded_op_o = DCODED_ILLEGAL;
		endcase
	end

endmodule

/* rtl/riscv_pkg.sv */
// RV32I decode definitions
package riscv_pkg;

	typedef enum logic [5:0] {
		DCODED_ADD,
		DCODED_SUB,
		DCODED_SLL,
		DCODED_SRL,
		DCODED_SRA,
		DCODED_AND,
		DCODED_OR,
		DCODED_XOR,
		DCODED_SLT,
		DCODED_SLTU,
		DCODED_ADDI,
		DCODED_SLLI,
		DCODED_SRLI,
		DCODED_SRAI,
		DCODED_ANDI,
		DCODED_ORI,
		DCODED_XORI,
		DCODED_SLTI,
		DCODED_SLTIU,
		DCODED_LUI,
		DCODED_AUIPC,
		DCODED_LB,
		DCODED_LBU,
		DCODED_LH,
		DCODED_LHU,
		DCODED_LW,
		DCODED_SB,
		DCODED_SH,
		DCODED_SW,
		DCODED_BEQ,
		DCODED_BNE,
		DCODED_BLT,
		DCODED_BLTU,
		DCODED_BGE,
		DCODED_BGEU,
		DCODED_JAL,
		DCODED_JALR,
		DCODED_ILLEGAL
	} dcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	// Major opcodes in instr[6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_e;

endpackage
